/* verilog.f */
hw/cache_geom_pkg.sv
hw/cache_msg_pkg.sv
hw/way_array.sv
hw/cache_req_in.sv
hw/cache_ctrl.sv
hw/cache_ways.sv
hw/cache_resp_out.sv
hw/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
verilator --binary --timing --assert --top-module cache_tb -f verilog.f -o cache_sim
out=$(./obj_dir/cache_sim)
echo "$out"
echo "$out" | grep -qx "Verification passed"

/* tests/cache_tb.sv */
/*
 * Two-way cache testbench
 * Line memory model, reference model, directed and back-pressure tests
 */
module cache_tb
  import cache_geom_pkg::*, cache_msg_pkg::*;
();

  localparam int rand_reqs = 20;
  localparam int num_reqs  = 14 + rand_reqs;  // Directed plus random

  logic      clk, reset;
  logic      cachereq_val, cachereq_rdy, cacheresp_val, cacheresp_rdy, cacheresp_hit;
  logic      memreq_val, memreq_rdy, memresp_val, memresp_rdy;
  req_type_t cachereq_type, cacheresp_type;
  addr_t     cachereq_addr, memreq_addr;
  word_t     cachereq_data, cacheresp_data;
  opaque_t   cachereq_opaque, cacheresp_opaque;
  line_t     memresp_data;

  int unsigned cycle_cnt = 0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned fails_seen = 0;  // Failure total at the end of the last test
  bit          stall = 1'b0;    // Random back-pressure on both ready inputs

  // Reference model per set and way
  logic  ref_valid [num_sets][2] = '{default: 1'b0};
  tag_t  ref_tag   [num_sets][2];
  word_t ref_word  [num_sets][2][words_per_line];
  logic  ref_lru   [num_sets] = '{default: 1'b0};  // Set means way 1 is the victim

  cache_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  //--------------------------------------------------------------------
  // Line memory returning each word's own byte address
  //--------------------------------------------------------------------

  initial begin : memory_model
    addr_t line_addr;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    forever begin
      @(negedge clk);
      memreq_rdy = stall ? ($urandom_range(0, 1) == 1) : 1'b1;
      if (memreq_val && memreq_rdy) begin
        line_addr = memreq_addr;
        check_value("memreq_addr", memreq_addr, {cachereq_addr[31:4], 4'h0});
        repeat ($urandom_range(1, 5)) @(negedge clk);
        memresp_val = 1'b1;
        for (int i = 0; i < words_per_line; i++) begin
          memresp_data[i*data_w +: data_w] = line_addr + 4 * i;
        end
        while (!memresp_rdy) @(negedge clk);
        @(negedge clk);
        memresp_val = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (num_reqs * 40) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", num_reqs * 40);
    $display("Verification failed");
    $finish;
  end

  function automatic int unsigned failure_count();
    return errors + dut0.props0.fail_count;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Expected response before the model takes the access
  task automatic model_access(input req_type_t t, input addr_t a, input word_t d,
                              output logic exp_hit, output word_t exp_data);
    tag_t      tg;
    idx_t      ix;
    word_sel_t wd;
    int        way;
    tg = a[31:7];
    ix = a[6:4];
    wd = a[3:2];
    exp_hit = 1'b0;
    way = int'(ref_lru[ix]);
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[ix][w] && ref_tag[ix][w] == tg) begin
        exp_hit = 1'b1;
        way = w;
      end
    end
    if (!exp_hit) begin
      ref_valid[ix][way] = 1'b1;
      ref_tag[ix][way]   = tg;
      for (int i = 0; i < words_per_line; i++) begin
        // Unknown words after an init allocation
        ref_word[ix][way][i] = (t == req_init) ? 'x : {tg, ix, 4'h0} + 4 * i;
      end
    end
    if (t == req_init) begin
      ref_word[ix][way][wd] = d;
      exp_data = '0;
    end else begin
      exp_data = ref_word[ix][way][wd];
    end
    ref_lru[ix] = (way == 0);  // Other way goes stale
  endtask

  task automatic run_request(input req_type_t t, input addr_t a, input word_t d,
                             input bit check_latency);
    logic        exp_hit;
    word_t       exp_data;
    opaque_t     op;
    int unsigned accept_cyc;
    bit          seen;
    bit          done;
    op = opaque_t'($urandom);
    model_access(t, a, d, exp_hit, exp_data);
    @(negedge clk);
    cachereq_val    = 1'b1;
    cachereq_type   = t;
    cachereq_addr   = a;
    cachereq_data   = d;
    cachereq_opaque = op;
    while (!cachereq_rdy) @(negedge clk);
    accept_cyc = cycle_cnt + 1;  // Taken on the coming rising edge
    @(negedge clk);
    cachereq_val = 1'b0;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      cacheresp_rdy = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
      if (cacheresp_val && !seen && check_latency) begin
        check_value("cacheresp_val delay", cycle_cnt - accept_cyc, 3);
      end
      seen = seen || cacheresp_val;
      if (cacheresp_val && cacheresp_rdy) begin
        check_value("cacheresp_type", 32'(cacheresp_type), 32'(t));
        check_value("cacheresp_opaque", 32'(cacheresp_opaque), 32'(op));
        check_value("cacheresp_data", cacheresp_data, exp_data);
        check_value("cacheresp_hit", 32'(cacheresp_hit), 32'(exp_hit));
        done = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (failure_count() == fails_seen) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failures", name, failure_count() - fails_seen);
    end
    fails_seen = failure_count();
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin : stimulus
    addr_t a;
    void'($urandom(76));
    reset           = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = req_read;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cachereq_opaque = '0;
    cacheresp_rdy   = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("cachereq_rdy", 32'(cachereq_rdy), 1);
    check_value("cacheresp_val", 32'(cacheresp_val), 0);
    check_value("memreq_val", 32'(memreq_val), 0);
    run_request(req_read, 32'h0000_0100, '0, 1'b0);  // Cold cache
    end_test("reset state");
    run_request(req_read, 32'h0000_0240, '0, 1'b0);
    run_request(req_read, 32'h0000_0248, '0, 1'b1);
    end_test("read miss then hit");
    run_request(req_init, 32'h0000_0384, 32'hcafe_0001, 1'b1);  // Allocates a way
    run_request(req_read, 32'h0000_0384, '0, 1'b1);
    run_request(req_init, 32'h0000_024c, 32'h5a5a_0003, 1'b1);  // Merges into a cached line
    run_request(req_read, 32'h0000_024c, '0, 1'b1);
    run_request(req_read, 32'h0000_0244, '0, 1'b1);
    end_test("init then read");
    // Lines A, B and C share set 2
    run_request(req_read, 32'h0000_1020, '0, 1'b0);
    run_request(req_read, 32'h0000_2024, '0, 1'b0);
    run_request(req_read, 32'h0000_1028, '0, 1'b1);
    run_request(req_read, 32'h0000_302c, '0, 1'b0);  // B is the victim
    run_request(req_read, 32'h0000_1020, '0, 1'b1);
    run_request(req_read, 32'h0000_2020, '0, 1'b0);
    end_test("lru replacement");
    stall = 1'b1;
    for (int i = 0; i < rand_reqs; i++) begin
      a = {25'($urandom_range(0, 3)), 3'($urandom_range(0, 7)),
           2'($urandom_range(0, 3)), 2'b00};
      run_request(req_read, a, '0, 1'b0);
    end
    end_test("back-pressure");
    $display("%0d tests, %0d failed, %0d checks, %0d failures",
             tests_run, tests_failed, checks, failure_count());
    if (failure_count() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tests/cache_properties.sv */
/*
 * Cache handshake properties
 * Response and memory request hold under back-pressure and one request at a time
 */
module cache_properties
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input logic      clk, reset,
  input logic      cachereq_rdy, cacheresp_val, cacheresp_rdy, cacheresp_hit,
  input logic      memreq_val, memreq_rdy,
  input req_type_t cacheresp_type,
  input opaque_t   cacheresp_opaque,
  input word_t     cacheresp_data,
  input addr_t     memreq_addr
);

  int unsigned fail_count = 0;

  // Stalled response keeps every field
  response_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_type)
      && $stable(cacheresp_opaque) && $stable(cacheresp_data) && $stable(cacheresp_hit))
  else begin
    $error("cache response changed while stalled");
    fail_count++;
  end

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_addr))
  else begin
    $error("memory request dropped or changed while stalled");
    fail_count++;
  end

  // One request at a time
  busy_while_pending: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val |-> !cachereq_rdy)
  else begin
    $error("cache accepts a request while a response is pending");
    fail_count++;
  end

endmodule

bind cache_top cache_properties props0 (.*);

/* hw/cache_top.sv */
/*
 * Two-way blocking cache
 * Request stage, controller, way storage and response stage
 */
module cache_top
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  logic      cachereq_val,
  output logic      cachereq_rdy,
  input  req_type_t cachereq_type,
  input  addr_t     cachereq_addr,
  input  word_t     cachereq_data,
  input  opaque_t   cachereq_opaque,

  output logic      cacheresp_val,
  input  logic      cacheresp_rdy,
  output req_type_t cacheresp_type,
  output opaque_t   cacheresp_opaque,
  output word_t     cacheresp_data,
  output logic      cacheresp_hit,

  output logic      memreq_val,
  input  logic      memreq_rdy,
  output addr_t     memreq_addr,

  input  logic      memresp_val,
  output logic      memresp_rdy,
  input  line_t     memresp_data
);

  req_type_t                 req_type;
  tag_t                      req_tag;
  idx_t                      req_idx;
  word_sel_t                 req_word;
  word_t                     req_data;
  opaque_t                   req_opaque;
  logic [words_per_line-1:0] word_en;
  logic                      req_load;
  logic                      tag_read;
  logic                      init_write;
  logic                      refill_write;
  logic                      lru_touch;
  logic                      resp_load;
  logic                      hit;
  word_t                     read_word;

  cache_req_in req_in (
    .clk, .reset, .req_load,
    .cachereq_type, .cachereq_addr, .cachereq_data, .cachereq_opaque,
    .req_type, .req_tag, .req_idx, .req_word, .req_data, .req_opaque, .word_en
  );

  cache_ctrl ctrl (
    .clk, .reset, .cachereq_val, .cacheresp_rdy, .memreq_rdy, .memresp_val,
    .req_type, .hit,
    .cachereq_rdy, .cacheresp_val, .memreq_val, .memresp_rdy, .req_load,
    .tag_read, .init_write, .refill_write, .lru_touch, .resp_load
  );

  cache_ways ways (
    .clk, .reset, .tag_read, .init_write, .refill_write, .lru_touch,
    .req_tag, .req_idx, .req_word, .req_data, .word_en, .memresp_data,
    .hit, .read_word
  );

  cache_resp_out resp_out (
    .clk, .reset, .resp_load, .req_type, .req_opaque, .req_tag, .req_idx,
    .hit, .read_word,
    .cacheresp_type, .cacheresp_opaque, .cacheresp_data, .cacheresp_hit, .memreq_addr
  );

endmodule

/* hw/cache_resp_out.sv */
/*
 * Cache response output stage
 * Response register and line-aligned refill address
 */
module cache_resp_out
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      resp_load,
  input  req_type_t req_type,
  input  opaque_t   req_opaque,
  input  tag_t      req_tag,
  input  idx_t      req_idx,
  input  logic      hit,
  input  word_t     read_word,
  output req_type_t cacheresp_type,
  output opaque_t   cacheresp_opaque,
  output word_t     cacheresp_data,
  output logic      cacheresp_hit,
  output addr_t     memreq_addr
);

  // Loaded when the access state ends, held through back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      cacheresp_type   <= req_read;
      cacheresp_opaque <= '0;
      cacheresp_data   <= '0;
      cacheresp_hit    <= 1'b0;
    end else if (resp_load) begin
      cacheresp_type   <= req_type;
      cacheresp_opaque <= req_opaque;
      cacheresp_data   <= (req_type == req_read) ? read_word : '0;  // Init gives zero
      cacheresp_hit    <= hit;  // Still the tag check result after a refill
    end
  end

  assign memreq_addr = {req_tag, req_idx, {off_w{1'b0}}};  // Line aligned

endmodule

/* hw/cache_ways.sv */
/*
 * Two-way tag and line storage
 * Valid and LRU state, hit detection, victim choice and line write merge
 */
module cache_ways
  import cache_geom_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      tag_read,
  input  logic                      init_write,
  input  logic                      refill_write,
  input  logic                      lru_touch,
  input  tag_t                      req_tag,
  input  idx_t                      req_idx,
  input  word_sel_t                 req_word,
  input  word_t                     req_data,
  input  logic [words_per_line-1:0] word_en,
  input  line_t                     memresp_data,
  output logic                      hit,
  output word_t                     read_word
);

  tag_t                      tag_rd [2];
  line_t                     line_rd [2];
  line_t                     line_sel;
  line_t                     line_wdata;
  line_t                     line_mask;
  line_t                     init_mask;
  logic [1:0][num_sets-1:0]  valid;
  logic [num_sets-1:0]       lru_bits;   // Set bit means way 1 is the victim
  logic [1:0]                valid_q;    // Sampled with the tag read
  logic                      lru_q;
  logic [1:0]                tag_match;
  logic                      hit_way;
  logic                      way_sel;
  logic                      alloc;

  //----------------------------------------------------------------------
  // Hit detection and way choice
  //----------------------------------------------------------------------

  assign tag_match[0] = valid_q[0] && (tag_rd[0] == req_tag);
  assign tag_match[1] = valid_q[1] && (tag_rd[1] == req_tag);
  assign hit          = |tag_match;
  assign hit_way      = tag_match[1];
  assign way_sel      = hit ? hit_way : lru_q;  // Hit way, else the LRU victim

  // New tag and valid only when the line changes owner
  assign alloc = refill_write || (init_write && !hit);

  always_comb begin
    for (int w = 0; w < words_per_line; w++) begin
      init_mask[w*data_w +: data_w] = {data_w{word_en[w]}};
    end
  end

  assign line_wdata = refill_write ? memresp_data : {words_per_line{req_data}};
  assign line_mask  = refill_write ? '1 : init_mask;

  //----------------------------------------------------------------------
  // Tag and line arrays
  //----------------------------------------------------------------------

  for (genvar w = 0; w < 2; w++) begin : g_way
    way_array #(.entry_t(tag_t)) tag_array (
      .clk        (clk),
      .read_en    (tag_read),
      .read_idx   (req_idx),
      .write_en   (alloc && (way_sel == w)),
      .write_idx  (req_idx),
      .write_data (req_tag),
      .write_mask ('1),
      .read_data  (tag_rd[w])
    );

    way_array #(.entry_t(line_t)) line_array (
      .clk        (clk),
      .read_en    (tag_read || refill_write),  // Refill reads back the new line
      .read_idx   (req_idx),
      .write_en   ((refill_write || init_write) && (way_sel == w)),
      .write_idx  (req_idx),
      .write_data (line_wdata),
      .write_mask (line_mask),
      .read_data  (line_rd[w])
    );
  end

  assign line_sel  = line_rd[way_sel];
  assign read_word = line_sel[req_word*data_w +: data_w];

  //----------------------------------------------------------------------
  // Valid and LRU state
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid    <= '0;
      lru_bits <= '0;
      valid_q  <= '0;
      lru_q    <= 1'b0;
    end else begin
      if (tag_read) begin
        valid_q <= {valid[1][req_idx], valid[0][req_idx]};
        lru_q   <= lru_bits[req_idx];
      end
      if (alloc)     valid[way_sel][req_idx] <= 1'b1;
      if (lru_touch) lru_bits[req_idx]       <= !way_sel;  // Other way goes stale
    end
  end

endmodule

/* hw/cache_ctrl.sv */
/*
 * Blocking cache controller
 * One request at a time through tag check, access and line refill
 */
module cache_ctrl
  import cache_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      cachereq_val,
  input  logic      cacheresp_rdy,
  input  logic      memreq_rdy,
  input  logic      memresp_val,
  input  req_type_t req_type,
  input  logic      hit,
  output logic      cachereq_rdy,
  output logic      cacheresp_val,
  output logic      memreq_val,
  output logic      memresp_rdy,
  output logic      req_load,
  output logic      tag_read,
  output logic      init_write,
  output logic      refill_write,
  output logic      lru_touch,
  output logic      resp_load
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        tc_ready;    // Array read has come back
  logic        refill_cs;
  logic [9:0]  cs;

  //----------------------------------------------------------------------
  // State register
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      tc_ready <= 1'b0;
    end else begin
      state    <= state_next;
      tc_ready <= (state == st_tag_check) && !tc_ready;
    end
  end

  //----------------------------------------------------------------------
  // Next state
  //----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (cachereq_val) state_next = st_tag_check;
      end
      st_tag_check: begin
        // First cycle issues the read, second one decides
        if (tc_ready) begin
          if (req_type == req_init) state_next = st_init_access;
          else if (hit)             state_next = st_read_access;
          else                      state_next = st_refill_request;
        end
      end
      st_init_access:    state_next = st_resp_wait;
      st_read_access:    state_next = st_resp_wait;
      st_refill_request: begin
        if (memreq_rdy) state_next = st_refill_wait;
      end
      st_refill_wait: begin
        if (memresp_val) state_next = st_refill_update;
      end
      st_refill_update:  state_next = st_read_access;  // Line read-back settles
      st_resp_wait: begin
        if (cacheresp_rdy) state_next = st_idle;
      end
      default:           state_next = st_idle;
    endcase
  end

  //----------------------------------------------------------------------
  // Control signal table
  //----------------------------------------------------------------------

  always_comb begin
    case (state)
      //                    creq cresp mreq mresp load tag  init refl lru  resp
      //                    rdy  val   val  rdy        rd   wr   wr   tch  load
      st_idle:           cs = {1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      st_tag_check:      cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      st_init_access:    cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
      st_read_access:    cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
      st_refill_request: cs = {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      st_refill_wait:    cs = {1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      st_refill_update:  cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      st_resp_wait:      cs = {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      default:           cs = '0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy, req_load,
          tag_read, init_write, refill_cs, lru_touch, resp_load} = cs;

  assign refill_write = refill_cs && memresp_val;  // Line written on the handshake

endmodule

/* hw/cache_req_in.sv */
/*
 * Cache request input stage
 * Holds the accepted request and splits its address into cache fields
 */
module cache_req_in
  import cache_geom_pkg::*, cache_msg_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_load,
  input  req_type_t                 cachereq_type,
  input  addr_t                     cachereq_addr,
  input  word_t                     cachereq_data,
  input  opaque_t                   cachereq_opaque,
  output req_type_t                 req_type,
  output tag_t                      req_tag,
  output idx_t                      req_idx,
  output word_sel_t                 req_word,
  output word_t                     req_data,
  output opaque_t                   req_opaque,
  output logic [words_per_line-1:0] word_en
);

  addr_t req_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_type   <= req_read;
      req_addr   <= '0;
      req_data   <= '0;
      req_opaque <= '0;
    end else if (req_load) begin
      req_type   <= cachereq_type;
      req_addr   <= cachereq_addr;
      req_data   <= cachereq_data;
      req_opaque <= cachereq_opaque;
    end
  end

  // Field split of the held address
  assign req_tag  = req_addr[addr_w-1 -: tag_w];
  assign req_idx  = req_addr[off_w +: idx_w];
  assign req_word = req_addr[off_w-1:2];  // Byte offset within word dropped

  assign word_en = words_per_line'(1) << req_word;  // One-hot enable for init writes

endmodule

/* hw/way_array.sv */
/*
 * Per-way storage array
 * Synchronous read, bit-masked write, new data returned on a same-entry read
 */
module way_array
  import cache_geom_pkg::*;
#(
  parameter type entry_t = logic
) (
  input  logic   clk,
  input  logic   read_en,
  input  idx_t   read_idx,
  input  logic   write_en,
  input  idx_t   write_idx,
  input  entry_t write_data,
  input  entry_t write_mask,
  output entry_t read_data
);

  entry_t mem [num_sets];
  entry_t merged;

  assign merged = (mem[write_idx] & ~write_mask) | (write_data & write_mask);

  always_ff @(posedge clk) begin
    if (write_en) mem[write_idx] <= merged;
    if (read_en) begin
      if (write_en && (write_idx == read_idx)) read_data <= merged;  // Write-first
      else                                     read_data <= mem[read_idx];
    end
  end

endmodule

/* hw/cache_msg_pkg.sv */
/*
 * Cache message and control types
 * Request codes, requester tag and controller state encoding
 */
package cache_msg_pkg;

  localparam int opaque_w = 8;

  typedef logic [2:0] req_type_t;

  // Request type codes
  localparam req_type_t req_read = 3'd0;
  localparam req_type_t req_init = 3'd2;

  typedef logic [opaque_w-1:0] opaque_t;  // Echoed back untouched

  typedef enum logic [3:0] {
    st_idle           = 4'd0,
    st_tag_check      = 4'd1,
    st_init_access    = 4'd2,
    st_read_access    = 4'd3,
    st_refill_request = 4'd4,
    st_refill_wait    = 4'd5,
    st_refill_update  = 4'd6,
    st_resp_wait      = 4'd7
  } ctrl_state_t;

endpackage

/* hw/cache_geom_pkg.sv */
/*
 * Cache geometry
 * Address split and storage sizes for the 256-byte two-way cache
 */
package cache_geom_pkg;

  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int line_w         = 128;
  localparam int words_per_line = line_w / data_w;  // 4 words
  localparam int num_sets       = 8;                // 2 ways each
  localparam int off_w          = $clog2(line_w / 8);
  localparam int idx_w          = $clog2(num_sets);
  localparam int tag_w          = addr_w - idx_w - off_w;  // Bits 31..7

  typedef logic [addr_w-1:0]                  addr_t;
  typedef logic [data_w-1:0]                  word_t;
  typedef logic [line_w-1:0]                  line_t;
  typedef logic [tag_w-1:0]                   tag_t;
  typedef logic [idx_w-1:0]                   idx_t;
  typedef logic [$clog2(words_per_line)-1:0]  word_sel_t;

endpackage
